/* include/stack_cfg.svh */
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

// Sizing of the LIFO stack, shared by the RTL and the testbench

// Number of entries the stack can hold
// Must be a power of two and at least 2 so the address width stays exact
`define STACK_DEPTH 16

// Width in bits of one stored word
`define STACK_DATA_W 16

// Width of the stack pointer, which doubles as the entry count
// One bit wider than the address so that a completely full stack
// (count equal to the depth) can still be represented
`define STACK_PTR_W ($clog2(`STACK_DEPTH) + 1)

// The memory address is the pointer minus its top bit
// Derived here so that every user agrees on the same width
`define STACK_ADDR_W (`STACK_PTR_W - 1)

`endif

/* hw/stack_pkg.sv */
`include "stack_cfg.svh"

package stack_pkg;

  // Operation carried by one requester handshake
  // Only one of the two is ever in flight, so a single bit is enough
  typedef enum logic {
    OP_PUSH = 1'b0,
    OP_POP  = 1'b1
  } stack_op_t;

  // Payload word held in each stack entry
  // The storage array is generic and gets this type bound at the top level
  typedef logic [`STACK_DATA_W-1:0] stack_word_t;

endpackage : stack_pkg

/* hw/stack_mem.sv */
`include "stack_cfg.svh"

module stack_mem #(
// Entry type, bound by the parent to the payload it stores
  parameter type entry_t = logic [`STACK_DATA_W-1:0]
) (
// Clock, no reset since the array holds only payload
  input  wire logic                       clk

// Write and read strobes from the controller, one at a time
, input  wire logic                       i_wen
, input  wire logic                       i_ren
, input  wire logic [`STACK_ADDR_W-1:0]   i_addr

// Write data and registered read data
, input  entry_t                          i_wdata
, output entry_t                          o_rdata
);

  localparam int DEPTH = `STACK_DEPTH;

  // One storage location per stack entry
  entry_t mem [DEPTH];

  // Synchronous write at the addressed entry
  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // Read data is registered one edge after the read strobe
  // and otherwise keeps the last value read
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_addr];
    end
  end

  // A stack command is either a push or a pop, so the controller
  // should never ask for both in one cycle
  a_no_rw_same_cycle : assert property (@(posedge clk)
    !(i_wen && i_ren));

endmodule : stack_mem

/* hw/stack_cntrl.sv */
`include "stack_cfg.svh"

module stack_cntrl import stack_pkg::*; (
// Clock and synchronous reset
  input  wire logic                       clk
, input  wire logic                       i_rst_n

// One-cycle command pulses from the requester port
, input  wire logic                       i_push
, input  wire logic                       i_pop

// Strobes and address for the storage array
, output wire logic                       o_mem_wen
, output wire logic                       o_mem_ren
, output wire logic [`STACK_ADDR_W-1:0]   o_mem_addr

// Refusal of the current command, valid in the same cycle
, output wire logic                       o_reject

// Status
, output wire logic                       o_full
, output wire logic                       o_empty
, output wire logic [`STACK_PTR_W-1:0]    o_count
);

  localparam int DEPTH  = `STACK_DEPTH;
  localparam int PTR_W  = `STACK_PTR_W;
  localparam int ADDR_W = `STACK_ADDR_W;

  // The pointer is the number of stored entries
  logic [PTR_W-1:0]  ptr_r;
  logic [PTR_W-1:0]  ptr_dec;
  logic [PTR_W-1:0]  ptr_nxt;
  logic              full_r;
  logic              empty_r;
  logic              push_ok;
  logic              pop_ok;
  stack_op_t         op;

  // Only accepted commands touch the memory or the pointer
  // A push is refused when full and a pop is refused when empty
  assign push_ok = i_push & ~full_r;
  assign pop_ok  = i_pop & ~empty_r;

  // Decode the pulse into an operation for the address select
  // With no command the push address is presented, but no strobe goes out
  assign op = i_pop ? OP_POP : OP_PUSH;

  assign ptr_dec = ptr_r - PTR_W'(1);

  // Push writes at the pointer, pop reads the entry just below it
  assign o_mem_addr = (op == OP_PUSH) ? ptr_r[ADDR_W-1:0] : ptr_dec[ADDR_W-1:0];

  // Next pointer value for an accepted command
  always_comb begin
    ptr_nxt = ptr_r;
    if (push_ok) begin
      ptr_nxt = ptr_r + PTR_W'(1);
    end else if (pop_ok) begin
      ptr_nxt = ptr_dec;
    end
  end

  // Flags are registered alongside the pointer so the status outputs
  // come straight from flops
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ptr_r   <= '0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else if (push_ok | pop_ok) begin
      ptr_r   <= ptr_nxt;
      full_r  <= (ptr_nxt == PTR_W'(DEPTH));
      empty_r <= (ptr_nxt == '0);
    end
  end

  assign o_mem_wen = push_ok;
  assign o_mem_ren = pop_ok;

  // A refused command leaves the stack unchanged and is only reported
  assign o_reject = (i_push & full_r) | (i_pop & empty_r);

  assign o_full  = full_r;
  assign o_empty = empty_r;
  assign o_count = ptr_r;

  // The port issues one command at a time, never both at once
  a_one_cmd : assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_push && i_pop));

  // Refusals must keep the count within the array
  a_count_range : assert property (@(posedge clk) disable iff (!i_rst_n)
    ptr_r <= PTR_W'(DEPTH));

  // The two flags describe opposite ends of the pointer range
  a_flags_excl : assert property (@(posedge clk) disable iff (!i_rst_n)
    !(full_r && empty_r));

endmodule : stack_cntrl

/* hw/stack_port.sv */
module stack_port import stack_pkg::*; (
// Clock and synchronous reset
  input  wire logic                       clk
, input  wire logic                       i_rst_n

// Four-phase requester side
, input  wire logic                       i_req
, input  stack_op_t                       i_op
, input  stack_word_t                     i_wdata
, output wire logic                       o_ack
, output stack_word_t                     o_rdata
, output logic                            o_err

// Command pulses and write data towards the controller and memory
, output wire logic                       o_push
, output wire logic                       o_pop
, output stack_word_t                     o_wdata

// Same-cycle refusal from the controller and registered memory data
, input  wire logic                       i_reject
, input  stack_word_t                     i_mem_rdata
);

  // Handshake progress for one operation
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ISSUE = 2'd1,
    ST_WAIT  = 2'd2,
    ST_ACK   = 2'd3
  } state_t;

  state_t       state_r;
  state_t       state_nxt;
  stack_op_t    op_r;
  stack_word_t  wdata_r;

  // Walk through issue and read wait, then hold the acknowledge until
  // the requester drops its request
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        if (i_req) begin
          state_nxt = ST_ISSUE;
        end
      end
      // The command pulse lasts exactly this one cycle
      ST_ISSUE: begin
        state_nxt = ST_WAIT;
      end
      // The memory read lands at the end of this cycle's predecessor
      ST_WAIT: begin
        state_nxt = ST_ACK;
      end
      ST_ACK: begin
        if (!i_req) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_nxt;
    end
  end

  // Capture the request once, when it is first seen
  // The command pulse and the write data are driven from this copy
  always_ff @(posedge clk) begin
    if (state_r == ST_IDLE && i_req) begin
      op_r    <= i_op;
      wdata_r <= i_wdata;
    end
  end

  // Refusal is only meaningful while the pulse is out, so record it then
  // Cleared when a new request is taken so stale errors do not linger
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_err <= 1'b0;
    end else if (state_r == ST_IDLE && i_req) begin
      o_err <= 1'b0;
    end else if (state_r == ST_ISSUE) begin
      o_err <= i_reject;
    end
  end

  // Memory data becomes valid one edge after the read strobe
  always_ff @(posedge clk) begin
    if (state_r == ST_WAIT) begin
      o_rdata <= i_mem_rdata;
    end
  end

  assign o_push  = (state_r == ST_ISSUE) && (op_r == OP_PUSH);
  assign o_pop   = (state_r == ST_ISSUE) && (op_r == OP_POP);
  assign o_wdata = wdata_r;

  // The acknowledge is high for the whole of the acknowledged state
  assign o_ack = (state_r == ST_ACK);

  // The acknowledge only rises on an edge where the request is still held
  // The requester may drop the request as soon as it sees the acknowledge
  a_ack_needs_req : assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(o_ack) |-> $past(i_req));

  // Push and pop pulses are exclusive and single cycle
  a_cmd_excl : assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_push && o_pop));
  a_push_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_push |=> !o_push);
  a_pop_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_pop |=> !o_pop);

endmodule : stack_port

/* hw/stack_top.sv */
`include "stack_cfg.svh"

module stack_top import stack_pkg::*; (
// Clock and synchronous reset
  input  wire logic                       clk
, input  wire logic                       i_rst_n

// Four-phase requester port
, input  wire logic                       i_req
, input  stack_op_t                       i_op
, input  stack_word_t                     i_wdata
, output wire logic                       o_ack
, output stack_word_t                     o_rdata
, output wire logic                       o_err

// Stack status
, output wire logic                       o_full
, output wire logic                       o_empty
, output wire logic [`STACK_PTR_W-1:0]    o_count
);

  // Commands from the port to the controller
  logic                      push;
  logic                      pop;
  logic                      reject;

  // Memory side
  logic                      mem_wen;
  logic                      mem_ren;
  logic [`STACK_ADDR_W-1:0]  mem_addr;
  stack_word_t               mem_wdata;
  stack_word_t               mem_rdata;

  // Requester front end
  stack_port u_port (
    .clk         (clk)
  , .i_rst_n     (i_rst_n)
  , .i_req       (i_req)
  , .i_op        (i_op)
  , .i_wdata     (i_wdata)
  , .o_ack       (o_ack)
  , .o_rdata     (o_rdata)
  , .o_err       (o_err)
  , .o_push      (push)
  , .o_pop       (pop)
  , .o_wdata     (mem_wdata)
  , .i_reject    (reject)
  , .i_mem_rdata (mem_rdata)
  );

  // Pointer, flags and accept decision
  stack_cntrl u_cntrl (
    .clk         (clk)
  , .i_rst_n     (i_rst_n)
  , .i_push      (push)
  , .i_pop       (pop)
  , .o_mem_wen   (mem_wen)
  , .o_mem_ren   (mem_ren)
  , .o_mem_addr  (mem_addr)
  , .o_reject    (reject)
  , .o_full      (o_full)
  , .o_empty     (o_empty)
  , .o_count     (o_count)
  );

  // Entry storage holding stack words
  stack_mem #(
    .entry_t     (stack_word_t)
  ) u_mem (
    .clk         (clk)
  , .i_wen       (mem_wen)
  , .i_ren       (mem_ren)
  , .i_addr      (mem_addr)
  , .i_wdata     (mem_wdata)
  , .o_rdata     (mem_rdata)
  );

endmodule : stack_top

/* sim/stack_tb.sv */
`include "stack_cfg.svh"

module stack_tb import stack_pkg::*; ();

  localparam int DEPTH    = `STACK_DEPTH;
  localparam int DATA_W   = `STACK_DATA_W;
  localparam int PTR_W    = `STACK_PTR_W;
  localparam int HALF_PER = 20;
  localparam int DRV_DLY  = 2;
  localparam int N_RANDOM = 250;

  // About 320 operations, each one takes at most 6 cycles through the handshake
  // The margin covers reset and rounds the limit up to 2500 cycles
  localparam int MAX_OPS     = 320;
  localparam int CYC_PER_OP  = 6;
  localparam int MARGIN_CYC  = 580;
  localparam int TIMEOUT_CYC = MAX_OPS * CYC_PER_OP + MARGIN_CYC;

  logic              clk;
  logic              i_rst_n;
  logic              i_req;
  stack_op_t         i_op;
  stack_word_t       i_wdata;
  logic              o_ack;
  stack_word_t       o_rdata;
  logic              o_err;
  logic              o_full;
  logic              o_empty;
  logic [PTR_W-1:0]  o_count;

  // Reference stack, the back of the queue is the top of the stack
  stack_word_t       model_q[$];

  // Expected response of the operation in flight
  stack_word_t       exp_rdata;
  logic              exp_err;
  logic              exp_chk_rd;
  logic [PTR_W-1:0]  exp_count;
  logic              exp_full;
  logic              exp_empty;

  // Handshake timing reference
  logic              exp_ack;
  logic [1:0]        req_edges;
  logic              rst_q = 1'b0;

  int                val_errs = 0;
  int                proto_errs = 0;
  int                cyc_cnt = 0;
  int                n;
  logic [31:0]       rnd;
  logic              going_up;
  stack_op_t         op;

  initial clk = 1'b0;
  always #HALF_PER clk = ~clk;

  stack_top uut (
    .clk      (clk)
  , .i_rst_n  (i_rst_n)
  , .i_req    (i_req)
  , .i_op     (i_op)
  , .i_wdata  (i_wdata)
  , .o_ack    (o_ack)
  , .o_rdata  (o_rdata)
  , .o_err    (o_err)
  , .o_full   (o_full)
  , .o_empty  (o_empty)
  , .o_count  (o_count)
  );

  // 32-bit xorshift, shifts 13, 17 and 5
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    val_errs++;
    $display("[ERROR] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_protocol(input string what);
    proto_errs++;
    $display("Protocol failure at time %0t: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("Value errors: %0d, protocol errors: %0d", val_errs, proto_errs);
  endtask

  // Works out the expected outcome from the pointer rule, then runs one
  // complete four-phase cycle
  // Called a short delay after a rising edge, with o_ack already low
  task automatic run_op(input stack_op_t cmd, input stack_word_t data);
    exp_chk_rd = 1'b0;
    if (cmd == OP_PUSH) begin
      exp_err = (model_q.size() == DEPTH);
      if (!exp_err) begin
        model_q.push_back(data);
      end
    end else begin
      exp_err = (model_q.size() == 0);
      if (!exp_err) begin
        exp_rdata  = model_q.pop_back();
        exp_chk_rd = 1'b1;
      end
    end
    exp_count = PTR_W'(model_q.size());
    exp_full  = (model_q.size() == DEPTH);
    exp_empty = (model_q.size() == 0);
    i_op    = cmd;
    i_wdata = data;
    i_req   = 1'b1;
    // Hold the request until the acknowledge shows up
    do begin
      @(posedge clk);
      #DRV_DLY;
    end while (!o_ack);
    i_req = 1'b0;
    // A new request may only start once the acknowledge is gone
    do begin
      @(posedge clk);
      #DRV_DLY;
    end while (o_ack);
  endtask

  // Acknowledge rises on the second edge after the request is first seen
  // and falls on the first edge that sees the request low
  always @(posedge clk) begin
    rst_q <= !i_rst_n;
    if (!i_rst_n) begin
      exp_ack   <= 1'b0;
      req_edges <= 2'd0;
    end else if (!exp_ack) begin
      if (i_req) begin
        if (req_edges == 2'd2) begin
          exp_ack   <= 1'b1;
          req_edges <= 2'd0;
        end else begin
          req_edges <= req_edges + 2'd1;
        end
      end
    end else if (!i_req) begin
      exp_ack <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      print_counts();
      $display("Finished with errors");
      $finish;
    end
  end

  // One edge into reset every output must already hold its reset value
  a_rst_ack : assert property (@(posedge clk) rst_q |-> !o_ack)
    else report_value("o_ack", 32'd0, 32'($sampled(o_ack)));
  a_rst_err : assert property (@(posedge clk) rst_q |-> !o_err)
    else report_value("o_err", 32'd0, 32'($sampled(o_err)));
  a_rst_empty : assert property (@(posedge clk) rst_q |-> o_empty)
    else report_value("o_empty", 32'd1, 32'($sampled(o_empty)));
  a_rst_full : assert property (@(posedge clk) rst_q |-> !o_full)
    else report_value("o_full", 32'd0, 32'($sampled(o_full)));
  a_rst_count : assert property (@(posedge clk) rst_q |-> o_count == '0)
    else report_value("o_count", 32'd0, 32'($sampled(o_count)));

  a_ack_timing : assert property (@(posedge clk) disable iff (!i_rst_n) o_ack == exp_ack)
    else report_protocol($sformatf("o_ack is %0b where the four-phase timing needs %0b",
                                   $sampled(o_ack), $sampled(exp_ack)));

  // Response fields are only meaningful while the acknowledge is high
  a_err : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack |-> o_err == exp_err)
    else report_value("o_err", 32'($sampled(exp_err)), 32'($sampled(o_err)));
  a_rdata : assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_ack && exp_chk_rd) |-> o_rdata == exp_rdata)
    else report_value("o_rdata", 32'($sampled(exp_rdata)), 32'($sampled(o_rdata)));
  a_count : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack |-> o_count == exp_count)
    else report_value("o_count", 32'($sampled(exp_count)), 32'($sampled(o_count)));
  a_full : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack |-> o_full == exp_full)
    else report_value("o_full", 32'($sampled(exp_full)), 32'($sampled(o_full)));
  a_empty : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack |-> o_empty == exp_empty)
    else report_value("o_empty", 32'($sampled(exp_empty)), 32'($sampled(o_empty)));

  initial begin
    i_rst_n    = 1'b0;
    i_req      = 1'b0;
    i_op       = OP_PUSH;
    i_wdata    = '0;
    exp_rdata  = '0;
    exp_err    = 1'b0;
    exp_chk_rd = 1'b0;
    exp_count  = '0;
    exp_full   = 1'b0;
    exp_empty  = 1'b1;
    rnd        = 32'd46602;
    going_up   = 1'b1;
    op         = OP_PUSH;
    repeat (3) @(posedge clk);
    #DRV_DLY;
    i_rst_n = 1'b1;
    @(posedge clk);
    #DRV_DLY;

    // Fill the stack completely
    for (n = 0; n < DEPTH; n++) begin
      rnd = xorshift32(rnd);
      run_op(OP_PUSH, rnd[DATA_W-1:0]);
    end
    // One more push must be refused
    rnd = xorshift32(rnd);
    run_op(OP_PUSH, rnd[DATA_W-1:0]);
    // Drain it, the words come back in reverse order
    for (n = 0; n < DEPTH; n++) begin
      run_op(OP_POP, '0);
    end
    // A pop from the empty stack must be refused
    run_op(OP_POP, '0);

    // Random mix that drifts towards full, then towards empty, and so on
    for (n = 0; n < N_RANDOM; n++) begin
      rnd = xorshift32(rnd);
      if (model_q.size() == DEPTH) begin
        going_up = 1'b0;
      end else if (model_q.size() == 0) begin
        going_up = 1'b1;
      end
      // Three out of four operations follow the current direction
      if ((rnd[31:30] != 2'b00) == going_up) begin
        op = OP_PUSH;
      end else begin
        op = OP_POP;
      end
      run_op(op, rnd[DATA_W-1:0]);
    end

    repeat (2) @(posedge clk);
    print_counts();
    if (val_errs + proto_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : stack_tb

/* filelist.f */
+incdir+include
hw/stack_pkg.sv
hw/stack_mem.sv
hw/stack_cntrl.sv
hw/stack_port.sv
hw/stack_top.sv
sim/stack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the stack testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

if ! verilator --binary --timing --assert \
    -f filelist.f \
    --top-module stack_tb \
    -Mdir "$build_dir"; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$("./$build_dir/Vstack_tb")
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi

echo "Simulation reported failures"
exit 1
